//--- wb_pkg.sv
package wb_pkg;

  localparam int adr_w = 25;  // word address
  localparam int dat_w = 32;
  localparam int sel_w = 4;   // one bit per byte lane

  typedef logic [adr_w-1:0] wb_adr_t;
  typedef logic [dat_w-1:0] wb_dat_t;
  typedef logic [sel_w-1:0] wb_sel_t;

  // one queued slave request, 62 bits
  typedef struct packed {
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
    wb_sel_t sel;
  } wb_req_t;

endpackage

//--- cache_pkg.sv
package cache_pkg;

  // address = {tag, index, word select}
  localparam int tag_w  = 13;
  localparam int idx_w  = 10;
  localparam int wsel_w = 2;

  localparam int line_words = 1 << wsel_w;
  localparam int n_lines    = 1 << idx_w;

  localparam int fifo_depth = 4;  // request queue entries

  typedef logic [tag_w-1:0] tag_t;
  typedef logic [idx_w-1:0] idx_t;
  typedef logic [wsel_w-1:0] wsel_t;

  // 146 bits: valid, per-word dirty, tag, words 3 down to 0
  typedef struct packed {
    logic                                 valid;
    logic [line_words-1:0]                dirty;
    tag_t                                 tag;
    wb_pkg::wb_dat_t [line_words-1:0]     data;
  } line_t;

endpackage

//--- req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  logic     pop_i,
  input  payload_t data_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);
  import cache_pkg::*;

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  payload_t           mem [fifo_depth];
  logic [ptr_w-1:0]   wr_ptr, rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               do_push, do_pop;

  assign full_o  = (count == cnt_w'(fifo_depth));
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr];  // fall-through head

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push)
      mem[wr_ptr] <= data_i;
  end

endmodule

//--- line_ram.sv
`timescale 1ns/1ps

module line_ram (
  input  logic             clk_i,
  input  cache_pkg::idx_t  addr_i,
  input  logic             we_i,
  input  cache_pkg::line_t wdata_i,
  output cache_pkg::line_t rdata_o
);
  import cache_pkg::*;

  line_t mem [n_lines];

  // registered read, old data on a write cycle
  always_ff @(posedge clk_i) begin
    if (we_i)
      mem[addr_i] <= wdata_i;
    rdata_o <= mem[addr_i];
  end

endmodule

//--- wb_slave_front.sv
`timescale 1ns/1ps

module wb_slave_front (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              s_cyc_i,
  input  logic              s_stb_i,
  input  logic              s_we_i,
  input  wb_pkg::wb_adr_t   s_adr_i,
  input  wb_pkg::wb_sel_t   s_sel_i,
  input  wb_pkg::wb_dat_t   s_dat_i,
  output logic              s_ack_o,
  output logic              push_o,
  output wb_pkg::wb_req_t   req_o,
  input  logic              full_i,
  input  logic              empty_i,
  input  logic              ctrl_idle_i
);

  typedef enum logic [1:0] {
    fe_idle,
    fe_rd_wait,
    fe_done
  } fe_state_t;

  fe_state_t state, state_next;

  assign push_o  = (state == fe_idle) && s_cyc_i && s_stb_i && !full_i;
  assign req_o   = '{we: s_we_i, adr: s_adr_i, dat: s_dat_i, sel: s_sel_i};
  assign s_ack_o = (state == fe_done);  // one-cycle pulse

  always_comb begin
    state_next = state;
    case (state)
      fe_idle:    if (push_o) state_next = s_we_i ? fe_done : fe_rd_wait;
      fe_rd_wait: if (empty_i && ctrl_idle_i) state_next = fe_done;  // all earlier work finished
      fe_done:    state_next = fe_idle;
      default:    state_next = fe_idle;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i)
      state <= fe_idle;
    else
      state <= state_next;
  end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
  input  logic              clk_i,
  input  logic              rst_i,
  input  wb_pkg::wb_req_t   head_i,
  input  logic              empty_i,
  output logic              pop_o,
  output logic              idle_o,
  output cache_pkg::idx_t   ram_addr_o,
  output logic              ram_we_o,
  output cache_pkg::line_t  ram_wdata_o,
  input  cache_pkg::line_t  ram_rdata_i,
  output wb_pkg::wb_dat_t   s_dat_o,
  output logic              m_cyc_o,
  output logic              m_stb_o,
  output logic              m_we_o,
  output wb_pkg::wb_adr_t   m_adr_o,
  output wb_pkg::wb_sel_t   m_sel_o,
  output wb_pkg::wb_dat_t   m_dat_o,
  input  wb_pkg::wb_dat_t   m_dat_i,
  input  logic              m_ack_i
);
  import wb_pkg::*;
  import cache_pkg::*;

  typedef enum logic [4:0] {
    st_init,
    st_idle,
    st_busy,
    st_busy2,
    st_hit,
    st_done,
    st_miss,
    st_fill1,
    st_fill2,
    st_fill3,
    st_fill4,
    st_fill_wr,
    st_flush1,
    st_flush2,
    st_flush3,
    st_flush4,
    st_flush_wr
  } ctrl_state_t;

  ctrl_state_t state, state_next;
  idx_t        init_cnt;
  wb_req_t     req_q;     // request under service
  line_t       line_q;    // working copy of the line
  tag_t        req_tag;
  idx_t        req_idx;
  wsel_t       req_wsel;
  wsel_t       beat;      // word of the current master cycle
  logic        hit;

  assign {req_tag, req_idx, req_wsel} = req_q.adr;

  assign hit = ram_rdata_i.valid && (ram_rdata_i.tag == req_tag);

  assign idle_o      = (state == st_idle);
  assign ram_addr_o  = (state == st_init) ? init_cnt : req_idx;
  assign ram_wdata_o = (state == st_init) ? '0 : line_q;

  assign m_stb_o = m_cyc_o;
  assign m_sel_o = '1;
  assign m_adr_o = {(m_we_o ? line_q.tag : req_tag), req_idx, beat};  // victim tag on write-back
  assign m_dat_o = m_we_o ? line_q.data[beat] : '0;

  always_comb begin
    state_next = state;
    pop_o      = 1'b0;
    ram_we_o   = 1'b0;
    m_cyc_o    = 1'b0;
    m_we_o     = 1'b0;
    beat       = '0;
    case (state)
      st_init: begin
        ram_we_o = 1'b1;  // zero line, valid cleared
        if (init_cnt == idx_t'(n_lines - 1))
          state_next = st_idle;
      end
      st_idle: begin
        if (!empty_i) begin
          pop_o      = 1'b1;
          state_next = st_busy;
        end
      end
      st_busy:  state_next = st_busy2;  // ram read in flight
      st_busy2: state_next = hit ? st_hit : st_miss;
      st_hit:   state_next = st_done;
      st_done: begin
        ram_we_o   = req_q.we;
        state_next = st_idle;
      end
      st_miss: state_next = line_q.valid ? st_flush1 : st_fill1;
      st_flush1, st_flush2, st_flush3, st_flush4: begin
        m_cyc_o = 1'b1;
        m_we_o  = 1'b1;
        beat    = wsel_t'(state - st_flush1);
        if (m_ack_i)
          state_next = (state == st_flush4) ? st_flush_wr : ctrl_state_t'(state + 1'b1);
      end
      st_flush_wr: begin
        ram_we_o   = 1'b1;
        state_next = st_fill1;
      end
      st_fill1, st_fill2, st_fill3, st_fill4: begin
        m_cyc_o = 1'b1;
        beat    = wsel_t'(state - st_fill1);
        if (m_ack_i)
          state_next = (state == st_fill4) ? st_fill_wr : ctrl_state_t'(state + 1'b1);
      end
      st_fill_wr: begin
        ram_we_o   = 1'b1;
        state_next = st_busy;  // look up again, now hits
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state    <= st_init;
      init_cnt <= '0;
    end else begin
      state <= state_next;
      if (state == st_init)
        init_cnt <= init_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o)
      req_q <= head_i;
    if (state == st_busy2)
      line_q <= ram_rdata_i;
    if (state == st_hit) begin
      if (req_q.we) begin
        for (int b = 0; b < sel_w; b++) begin
          if (req_q.sel[b])
            line_q.data[req_wsel][8*b +: 8] <= req_q.dat[8*b +: 8];
        end
        line_q.dirty[req_wsel] <= 1'b1;
      end else begin
        s_dat_o <= line_q.data[req_wsel];
      end
    end
    if (m_cyc_o && m_ack_i) begin
      line_q.dirty[beat] <= 1'b0;
      if (!m_we_o)
        line_q.data[beat] <= m_dat_i;
    end
    if (state == st_fill4 && m_ack_i) begin
      line_q.tag   <= req_tag;
      line_q.valid <= 1'b1;
    end
  end

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              s_cyc_i,
  input  logic              s_stb_i,
  input  logic              s_we_i,
  input  wb_pkg::wb_adr_t   s_adr_i,
  input  wb_pkg::wb_sel_t   s_sel_i,
  input  wb_pkg::wb_dat_t   s_dat_i,
  output wb_pkg::wb_dat_t   s_dat_o,
  output logic              s_ack_o,
  output logic              m_cyc_o,
  output logic              m_stb_o,
  output logic              m_we_o,
  output wb_pkg::wb_adr_t   m_adr_o,
  output wb_pkg::wb_sel_t   m_sel_o,
  output wb_pkg::wb_dat_t   m_dat_o,
  input  wb_pkg::wb_dat_t   m_dat_i,
  input  logic              m_ack_i
);
  import wb_pkg::*;
  import cache_pkg::*;

  logic    push, pop, full, empty, ctrl_idle;
  wb_req_t req_in, req_head;
  idx_t    ram_addr;
  logic    ram_we;
  line_t   ram_wdata, ram_rdata;

  wb_slave_front u_front (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .s_cyc_i    (s_cyc_i),
    .s_stb_i    (s_stb_i),
    .s_we_i     (s_we_i),
    .s_adr_i    (s_adr_i),
    .s_sel_i    (s_sel_i),
    .s_dat_i    (s_dat_i),
    .s_ack_o    (s_ack_o),
    .push_o     (push),
    .req_o      (req_in),
    .full_i     (full),
    .empty_i    (empty),
    .ctrl_idle_i(ctrl_idle)
  );

  req_fifo #(.payload_t(wb_req_t)) u_fifo (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .push_i (push),
    .pop_i  (pop),
    .data_i (req_in),
    .data_o (req_head),
    .full_o (full),
    .empty_o(empty)
  );

  cache_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .head_i     (req_head),
    .empty_i    (empty),
    .pop_o      (pop),
    .idle_o     (ctrl_idle),
    .ram_addr_o (ram_addr),
    .ram_we_o   (ram_we),
    .ram_wdata_o(ram_wdata),
    .ram_rdata_i(ram_rdata),
    .s_dat_o    (s_dat_o),
    .m_cyc_o    (m_cyc_o),
    .m_stb_o    (m_stb_o),
    .m_we_o     (m_we_o),
    .m_adr_o    (m_adr_o),
    .m_sel_o    (m_sel_o),
    .m_dat_o    (m_dat_o),
    .m_dat_i    (m_dat_i),
    .m_ack_i    (m_ack_i)
  );

  line_ram u_ram (
    .clk_i  (clk_i),
    .addr_i (ram_addr),
    .we_i   (ram_we),
    .wdata_i(ram_wdata),
    .rdata_o(ram_rdata)
  );

endmodule

//--- cache_props.sv
`timescale 1ns/1ps

module cache_props (
  input logic            clk_i,
  input logic            rst_i,
  input logic            cyc_i,
  input logic            we_i,
  input wb_pkg::wb_adr_t adr_i,
  input wb_pkg::wb_dat_t dat_i,
  input logic            ack_i,
  input logic            pop_i
);
  import cache_pkg::*;

  int unsigned fail_cnt = 0;  // watched from the testbench
  int unsigned since_rst;     // cycles out of reset, saturating

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i)
      since_rst <= 0;
    else if (since_rst < n_lines)
      since_rst <= since_rst + 1;
  end

  // each ack ends its word, next beat or bus released
  ack_advance: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && ack_i |=> !cyc_i || (adr_i != $past(adr_i)))
    else begin
      fail_cnt++;
      $error("master cycle repeated an acknowledged word");
    end

  // request held until the slave answers
  master_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && !ack_i |=> cyc_i && $stable(adr_i) && $stable(dat_i) && $stable(we_i))
    else begin
      fail_cnt++;
      $error("master request changed before ack");
    end

  // whole clearing sweep before the first pop
  init_before_pop: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> since_rst >= n_lines)
    else begin
      fail_cnt++;
      $error("request popped before line clearing finished");
    end

endmodule

bind cache_ctrl cache_props u_props (
  .clk_i  (clk_i),
  .rst_i  (rst_i),
  .cyc_i  (m_cyc_o),
  .we_i   (m_we_o),
  .adr_i  (m_adr_o),
  .dat_i  (m_dat_o),
  .ack_i  (m_ack_i),
  .pop_i  (pop_o)
);

//--- tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
  import wb_pkg::*;
  import cache_pkg::*;

  localparam int n_cold  = 4;
  localparam int n_merge = 6;   // three write/read pairs
  localparam int n_wb    = 2;
  localparam int n_burst = 8;   // written, then read back
  localparam int n_mix   = 200;
  localparam int n_evict = 4;
  localparam int n_req   = n_cold + n_merge + n_wb + 2 * n_burst + n_mix + n_evict;
  localparam int cycle_limit = n_lines + 400 * n_req;

  logic    clk_i, rst_i;
  logic    s_cyc_i, s_stb_i, s_we_i, s_ack_o;
  wb_adr_t s_adr_i;
  wb_sel_t s_sel_i;
  wb_dat_t s_dat_i, s_dat_o;
  logic    m_cyc_o, m_stb_o, m_we_o;
  logic    m_ack_i = 1'b0;
  wb_adr_t m_adr_o;
  wb_sel_t m_sel_o;
  wb_dat_t m_dat_o;
  wb_dat_t m_dat_i = '0;

  wb_dat_t mem [wb_adr_t];     // memory model, written words only
  wb_dat_t shadow [wb_adr_t];  // expected memory image
  wb_dat_t exp_q [$];          // read data still owed
  string   name_q [$];         // test of each owed read
  string   test_name = "reset";
  integer  seed = 32'hc8dc;
  integer  dly_seed = 32'hc8dc;
  int      wait_cnt = 0;
  int      cycles = 0;

  cache_top DUT (.*);

  function automatic wb_dat_t mem_default(wb_adr_t a);
    return (32'(a) * 32'h9e37_79b1) ^ {a[6:0], a};
  endfunction

  function automatic wb_dat_t mem_read(wb_adr_t a);
    return mem.exists(a) ? mem[a] : mem_default(a);
  endfunction

  function automatic wb_dat_t ref_read(wb_adr_t a);
    return shadow.exists(a) ? shadow[a] : mem_default(a);
  endfunction

  function automatic wb_dat_t merge_lanes(wb_dat_t old, wb_dat_t d, wb_sel_t sel);
    wb_dat_t w;
    w = old;
    for (int b = 0; b < sel_w; b++) begin
      if (sel[b])
        w[8*b +: 8] = d[8*b +: 8];
    end
    return w;
  endfunction

  function automatic wb_adr_t make_adr(tag_t tag, idx_t idx, wsel_t wsel);
    return {tag, idx, wsel};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "%s", why);
  endtask

  task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_mem(input string name, input wb_adr_t a);
    if (mem_read(a) !== ref_read(a))
      abort_run($sformatf("ERR %s: word %h expected %h, actual %h",
                          name, a, ref_read(a), mem_read(a)));
  endtask

  task automatic bus_cycle(input logic we, input wb_adr_t a, input wb_dat_t d,
                           input wb_sel_t sel);
    @(posedge clk_i);
    s_cyc_i <= 1'b1;
    s_stb_i <= 1'b1;
    s_we_i  <= we;
    s_adr_i <= a;
    s_dat_i <= d;
    s_sel_i <= sel;
    @(posedge clk_i);
    while (!s_ack_o)
      @(posedge clk_i);
    s_cyc_i <= 1'b0;
    s_stb_i <= 1'b0;
  endtask

  task automatic bus_write(input wb_adr_t a, input wb_dat_t d, input wb_sel_t sel);
    shadow[a] = merge_lanes(ref_read(a), d, sel);
    bus_cycle(1'b1, a, d, sel);
  endtask

  task automatic bus_read(input wb_adr_t a);
    exp_q.push_back(ref_read(a));
    name_q.push_back(test_name);
    bus_cycle(1'b0, a, '0, '1);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // slow memory, 0 to 3 extra wait cycles per word
  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      m_ack_i  <= 1'b0;
      wait_cnt <= 0;
    end else begin
      m_ack_i <= 1'b0;
      if (m_cyc_o && m_stb_o && !m_ack_i) begin
        if (wait_cnt == 0) begin
          m_ack_i <= 1'b1;
          if (m_we_o)
            mem[m_adr_o] = merge_lanes(mem_read(m_adr_o), m_dat_o, m_sel_o);
          else
            m_dat_i <= mem_read(m_adr_o);
          wait_cnt <= $random(dly_seed) & 3;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (s_ack_o && s_cyc_i && !s_we_i) begin
      if (exp_q.size() == 0)
        abort_run("read acknowledged with no read outstanding");
      else
        check_dat(name_q.pop_front(), exp_q.pop_front(), s_dat_o);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (DUT.u_ctrl.u_props.fail_cnt != 0)
      abort_run("a bus assertion on the cache controller failed");
    else if (cycles >= cycle_limit)
      abort_run($sformatf("run stopped by timeout after %0d cycles", cycles));
  end

  initial begin
    wb_adr_t a;
    wb_adr_t burst_q [$];
    wb_adr_t wr_q [$];
    rst_i   = 1'b1;
    s_cyc_i = 1'b0;
    s_stb_i = 1'b0;
    s_we_i  = 1'b0;
    s_adr_i = '0;
    s_sel_i = '0;
    s_dat_i = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    test_name = "cold_read";
    for (int i = 0; i < n_cold; i++)
      bus_read(make_adr(13'h0001, idx_t'(16 + i), wsel_t'(i)));

    test_name = "byte_merge";
    a = make_adr(13'h0002, 10'h020, 2'd1);
    bus_write(a, 32'h1122_3344, 4'b0011);
    bus_read(a);
    bus_write(a, 32'haabb_ccdd, 4'b1100);
    bus_read(a);
    bus_write(a, 32'h5566_7788, 4'b0101);
    bus_read(a);

    test_name = "write_back";
    a = make_adr(13'h0003, 10'h030, 2'd2);
    bus_write(a, 32'hdead_beef, 4'b1111);
    bus_read(make_adr(13'h0004, 10'h030, 2'd2));  // same index, evicts a
    check_mem(test_name, a);

    test_name = "posted_burst";
    for (int i = 0; i < n_burst; i++) begin
      a = wb_adr_t'($random(seed));
      burst_q.push_back(a);
      bus_write(a, $random(seed), wb_sel_t'($random(seed)));
    end
    foreach (burst_q[i])
      bus_read(burst_q[i]);

    test_name = "random_mix";
    for (int i = 0; i < n_mix; i++) begin
      a = make_adr(tag_t'(13'h0100 + ($random(seed) & 3)),
                   idx_t'(10'h200 + ($random(seed) & 3)), wsel_t'($random(seed)));
      if ($random(seed) & 1) begin
        bus_write(a, $random(seed), wb_sel_t'($random(seed)));
        wr_q.push_back(a);
      end else begin
        bus_read(a);
      end
    end
    for (int i = 0; i < n_evict; i++)
      bus_read(make_adr(13'h1fff, idx_t'(10'h200 + i), 2'd0));  // push out dirty lines
    foreach (wr_q[i])
      check_mem(test_name, wr_q[i]);

    @(posedge clk_i);  // last read compare done
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d reads were never acknowledged", exp_q.size()));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

//--- sim.f
wb_pkg.sv
cache_pkg.sv
req_fifo.sv
line_ram.sv
wb_slave_front.sv
cache_ctrl.sv
cache_top.sv
cache_props.sv
tb_cache.sv

//--- Bender.yml
package:
  name: wb_dcache

sources:
  - files:
      - wb_pkg.sv
      - cache_pkg.sv
      - req_fifo.sv
      - line_ram.sv
      - wb_slave_front.sv
      - cache_ctrl.sv
      - cache_top.sv
  - target: simulation
    files:
      - cache_props.sv
      - tb_cache.sv
